// File: Makefile
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_sincos \
		-f sim.f --Mdir $(OBJ_DIR) -o Vtb_sincos

run: compile
	./$(OBJ_DIR)/Vtb_sincos | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/sincos_chk.sv
`timescale 1ns/1ps

module sincos_chk (
   input    logic                   i_clk,
   input    logic                   i_nrst,
   input    logic                   i_req,      // request level of the caller
   input    logic                   i_ack,      // acknowledge level of the DUT
   input    vector_pkg::sincos_t    i_result    // DUT result word
);

   localparam int latency  = 19;       // edges from first req sample to ack
   localparam int drop_max = 3;        // edges for ack to clear after req drops

   logic [5:0] high_run;               // req sampled high this many edges in a row
   logic [5:0] low_run;                // req sampled low this many edges in a row

   // run-length counters, both saturate
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         high_run <= '0;
         low_run  <= '0;
      end else if (i_req) begin
         low_run  <= '0;
         if (high_run != '1) high_run <= high_run + 1'b1;
      end else begin
         high_run <= '0;
         if (low_run != '1) low_run <= low_run + 1'b1;
      end
   end

   ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_nrst)
      $rose(i_ack) |-> (high_run >= latency))
      else $error("o_ack rose without i_req held for the full latency");

   result_stable: assert property (@(posedge i_clk) disable iff (!i_nrst)
      (i_ack && $past(i_ack)) |-> $stable(i_result))
      else $error("o_result changed while o_ack was held high");

   ack_clears: assert property (@(posedge i_clk) disable iff (!i_nrst)
      (low_run >= drop_max) |-> !i_ack)
      else $error("o_ack still high three edges after i_req dropped");

endmodule

bind sincos_top sincos_chk u_chk (
   .i_clk      (i_clk),
   .i_nrst     (i_nrst),
   .i_req      (i_req),
   .i_ack      (o_ack),
   .i_result   (o_result)
);

// File: bench/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
   output   logic    o_clk,     // free running testbench clock
   output   logic    o_nrst     // active low reset, released after a few cycles
);

   localparam real half_period   = 2.0;   // 4 ns period
   localparam int  rst_cycles    = 5;     // edges with reset held low

   initial begin
      o_clk = 1'b0;
      forever #(half_period) o_clk = ~o_clk;
   end

   initial begin
      o_nrst = 1'b0;
      repeat (rst_cycles) @(posedge o_clk);
      #1 o_nrst = 1'b1;                   // release away from the edge
   end

endmodule

// File: bench/tb_sincos.sv
`timescale 1ns/1ps
`include "cordic_defs.svh"

module tb_sincos;

   localparam int  tol        = 4;        // allowed error per sample in lsb
   localparam int  latency    = 19;       // edges from req to ack
   localparam int  drop_max   = 3;        // edges for ack to fall after req drops
   localparam int  max_wait   = 40;       // cycles before any wait gives up
   localparam int  n_random   = 200;
   localparam real two_pi     = 6.283185307179586;

   logic                   clk;
   logic                   nrst;
   logic [`ANGLE_W-1:0]    theta;         // DUT angle input
   logic                   req;           // DUT request level
   vector_pkg::sincos_t    result;
   logic                   ack;

   int                     errors    = 0;
   int                     timeouts  = 0;
   int                     checked   = 0;  // results compared by the checker process
   int                     requests  = 0;  // requests that got an ack
   int                     seed      = 32'h995e3bf0;
   logic [`ANGLE_W-1:0]    req_theta = '0; // angle of the request in flight
   logic                   ack_seen  = 1'b0;

   tb_clkgen u_clkgen (.o_clk(clk), .o_nrst(nrst));

   sincos_top DUT (
      .i_clk      (clk),
      .i_nrst     (nrst),
      .i_theta    (theta),
      .i_req      (req),
      .o_result   (result),
      .o_ack      (ack)
   );

   // nearest integer with halves rounded away from zero
   function automatic int round_real(input real r);
      if (r >= 0.0)
         return $rtoi(r + 0.5);
      else
         return $rtoi(r - 0.5);
   endfunction

   // expected Q1.14 sin/cos straight from real math
   function automatic vector_pkg::sincos_t ref_sincos(input logic [`ANGLE_W-1:0] a);
      real                 ph;
      vector_pkg::sincos_t r;
      ph    = two_pi * real'(a) / (2.0 ** `ANGLE_W);
      r.sin = `DATA_W'(round_real(16384.0 * $sin(ph)));
      r.cos = `DATA_W'(round_real(16384.0 * $cos(ph)));
      return r;
   endfunction

   function automatic bit near(input logic signed [`DATA_W-1:0] got,
                               input logic signed [`DATA_W-1:0] exp);
      int d;
      d = int'(got) - int'(exp);
      return (d <= tol) && (d >= -tol);
   endfunction

   // compare once per rising ack at the falling edge where outputs are settled
   always @(negedge clk) begin : compare
      vector_pkg::sincos_t exp_r;
      if (!ack) begin
         ack_seen = 1'b0;
      end else if (!ack_seen) begin
         ack_seen = 1'b1;
         exp_r    = ref_sincos(req_theta);
         checked++;
         assert (near(result.sin, exp_r.sin)) else begin
            errors++;
            $display("FAIL t=%0t angle %0d: sin exp %0d got %0d",
                     $time, req_theta, exp_r.sin, result.sin);
         end
         assert (near(result.cos, exp_r.cos)) else begin
            errors++;
            $display("FAIL t=%0t angle %0d: cos exp %0d got %0d",
                     $time, req_theta, exp_r.cos, result.cos);
         end
      end
   end

   // raise req 1 ns after an edge and count edges until ack
   task automatic start_request(input logic [`ANGLE_W-1:0] a);
      int n;
      req_theta = a;
      theta     = a;
      req       = 1'b1;
      n         = 0;
      while (!ack && n < max_wait) begin
         @(posedge clk);
         #1;
         n++;
      end
      if (!ack) begin
         timeouts++;
         $display("timeout: no acknowledge within %0d cycles for angle %0d", max_wait, a);
      end else begin
         requests++;
         assert (n == latency) else begin
            errors++;
            $display("FAIL t=%0t angle %0d: ack latency exp %0d got %0d",
                     $time, a, latency, n);
         end
      end
   endtask

   // hold one more edge so the result is read and then drop req and wait for ack low
   task automatic end_request();
      int n;
      @(posedge clk);
      #1;
      req = 1'b0;
      n   = 0;
      while (ack && n < max_wait) begin
         @(posedge clk);
         #1;
         n++;
      end
      if (ack) begin
         timeouts++;
         $display("timeout: acknowledge stayed high %0d cycles after the request dropped",
                  max_wait);
      end else begin
         assert (n <= drop_max) else begin
            errors++;
            $display("FAIL t=%0t: ack fall exp <= %0d edges got %0d", $time, drop_max, n);
         end
      end
   endtask

   task automatic run_angle(input logic [`ANGLE_W-1:0] a);
      start_request(a);
      end_request();
   endtask

   // keep req high 10 more cycles and scramble the angle input meanwhile
   task automatic hold_test(input logic [`ANGLE_W-1:0] a);
      vector_pkg::sincos_t snap;
      start_request(a);
      if (ack) begin
         snap = result;
         repeat (10) begin
            theta = `ANGLE_W'($random(seed));   // must not reach the result
            @(posedge clk);
            #1;
            assert (ack && (result == snap)) else begin
               errors++;
               $display("FAIL t=%0t angle %0d: held result exp %h got %h ack %b",
                        $time, a, snap, result, ack);
            end
         end
      end
      end_request();
   endtask

   initial begin : stimulus
      int n;
      int q;
      theta = '0;
      req   = 1'b0;
      n     = 0;
      while (nrst !== 1'b1 && n < max_wait) begin
         @(posedge clk);
         #1;
         n++;
      end
      if (nrst !== 1'b1) begin
         timeouts++;
         $display("timeout: reset was never released");
      end
      @(posedge clk);
      #1;
      assert (!ack && (result == '0)) else begin
         errors++;
         $display("FAIL t=%0t: idle after reset exp ack 0 result 0 got ack %b result %h",
                  $time, ack, result);
      end
      for (q = 0; q < 4; q++) run_angle(`ANGLE_W'(q * 16384));   // quadrant axes
      for (q = 0; q < 8; q++) begin                               // eighth-turn points +-1
         run_angle(`ANGLE_W'(q * 8192 - 1));
         run_angle(`ANGLE_W'(q * 8192 + 1));
      end
      hold_test(`ANGLE_W'(12345));
      for (n = 0; n < n_random; n++) run_angle(`ANGLE_W'($random(seed)));
      $display("errors %0d, timeouts %0d, requests %0d, results checked %0d",
               errors, timeouts, requests, checked);
      if (errors == 0 && timeouts == 0 && checked == requests && requests == 221)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

// File: hw/angle_fold.sv
`timescale 1ns/1ps
`include "cordic_defs.svh"

module angle_fold (
   input    logic                   i_clk,
   input    logic                   i_nrst,
   input    logic [`ANGLE_W-1:0]    i_theta,       // binary angle, full turn 2^16
   input    logic                   i_req,         // request level from the caller
   output   angle_pkg::fold_t       o_fold,        // captured quadrant + folded angle
   output   logic                   o_fold_valid   // o_fold is loaded and stable
);

   logic                   first_req;     // i_req high, nothing captured yet
   angle_pkg::quadrant_t   quad_in;       // top two bits of the request
   logic [`Z_W-1:0]        z_in;          // low bits moved up to internal scale

   assign first_req  = i_req && !o_fold_valid;
   assign quad_in    = angle_pkg::quadrant_t'(i_theta[`ANGLE_W-1 -: 2]);
   // 14 lsbs are the angle inside the quadrant, x4 gives 2^16 per quadrant
   assign z_in       = `Z_W'({i_theta[`ANGLE_W-3:0], 2'b00});

   // valid follows the request with one edge of delay
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_fold_valid <= 1'b0;
      end else begin
         o_fold_valid <= i_req;        // drops one edge after i_req is seen low
      end
   end

   // capture once per request, later i_theta changes are ignored
   always_ff @(posedge i_clk) begin
      if (first_req) begin
         o_fold.quad <= quad_in;
         o_fold.z    <= z_in;
      end
   end

endmodule

// File: hw/angle_pkg.sv
`include "cordic_defs.svh"

package angle_pkg;

   // quadrant number, straight from the two msbs of the binary angle
   typedef enum logic [1:0] {
      Q0 = 2'd0,                 // 0 .. 90 deg
      Q1 = 2'd1,                 // 90 .. 180 deg
      Q2 = 2'd2,                 // 180 .. 270 deg
      Q3 = 2'd3                  // 270 .. 360 deg
   } quadrant_t;

   // angle after folding into the first quadrant
   // z counts in internal units, one quarter turn is 2^16
   typedef struct packed {
      quadrant_t           quad; // where the result gets unfolded to
      logic [`Z_W-1:0]     z;    // residual angle, always in [0, 2^16)
   } fold_t;

endpackage

// File: hw/atan_rom.sv
`timescale 1ns/1ps
`include "cordic_defs.svh"

module atan_rom (
   input    logic [3:0]       i_idx,   // micro-rotation number
   output   logic [`Z_W-1:0]  o_step   // atan(2^-i) scaled so a turn is 2^18
);

   // entry = round(atan(2^-i) / (2*pi) * 2^18)
   always_comb begin
      unique case (i_idx)
         4'd0:    o_step = `Z_W'(32768);  // 45.000 deg, an eighth of a turn
         4'd1:    o_step = `Z_W'(19344);  // 26.565 deg
         4'd2:    o_step = `Z_W'(10221);  // 14.036 deg
         4'd3:    o_step = `Z_W'(5188);   // 7.125 deg
         4'd4:    o_step = `Z_W'(2604);   // 3.576 deg
         4'd5:    o_step = `Z_W'(1303);   // 1.790 deg
         4'd6:    o_step = `Z_W'(652);    // 0.895 deg
         4'd7:    o_step = `Z_W'(326);    // 0.448 deg
         4'd8:    o_step = `Z_W'(163);    // 0.224 deg
         4'd9:    o_step = `Z_W'(81);     // 0.112 deg
         4'd10:   o_step = `Z_W'(41);     // 0.056 deg
         4'd11:   o_step = `Z_W'(20);     // 0.028 deg
         4'd12:   o_step = `Z_W'(10);     // 0.014 deg
         4'd13:   o_step = `Z_W'(5);      // 0.007 deg
         4'd14:   o_step = `Z_W'(3);      // 0.0035 deg
         4'd15:   o_step = `Z_W'(1);      // 0.0017 deg, below one input lsb
         default: o_step = '0;
      endcase
   end

   // from here on the table is just 2^18 / (2*pi) / 2^i, rounded
   // tail entries below 1 would be useless, so the table stops at 16

endmodule

// File: hw/cordic_iter.sv
`timescale 1ns/1ps
`include "cordic_defs.svh"

module cordic_iter (
   input    logic                   i_clk,
   input    logic                   i_nrst,
   input    logic [`Z_W-1:0]        i_fold_z,      // first-quadrant angle to rotate by
   input    logic                   i_fold_valid,  // level, high while a request runs
   output   logic [3:0]             o_step_idx,    // table address = current iteration
   input    logic [`Z_W-1:0]        i_step,        // atan step for o_step_idx
   output   vector_pkg::vec_t       o_vec,         // x = cos, y = sin (first quadrant)
   output   logic                   o_done         // level, all iterations finished
);

   localparam int frac_g   = `XY_W - `DATA_W;                  // guard fraction bits
   localparam int cnt_w    = $clog2(`CORDIC_ITER + 1);         // holds 0 .. 16
   localparam logic [cnt_w-1:0] iter_end = cnt_w'(`CORDIC_ITER);
   // start vector (1/K, 0), moved up onto the guard-bit grid
   localparam logic signed [`XY_W-1:0] x_init = `XY_W'(`CORDIC_X0 * (2 ** frac_g));

   logic                      loaded;        // start vector is in the registers
   logic [cnt_w-1:0]          count;         // micro-rotations done so far
   logic                      rot_en;        // rotate on this edge
   logic                      z_neg;         // residual angle below zero
   logic signed [`XY_W-1:0]   x_q, y_q;      // working vector
   logic signed [`Z_W-1:0]    z_q;           // residual angle
   logic signed [`XY_W-1:0]   x_sh, y_sh;    // x, y scaled by 2^-i
   logic signed [`Z_W-1:0]    step_s;        // table step as signed

   assign rot_en     = loaded && (count < iter_end);
   assign o_step_idx = count[3:0];
   assign z_neg      = z_q[`Z_W-1];
   assign x_sh       = x_q >>> o_step_idx;   // arithmetic, keeps the sign
   assign y_sh       = y_q >>> o_step_idx;
   assign step_s     = signed'(i_step);

   // control: idle -> load -> 16 rotations -> hold until valid drops
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         loaded <= 1'b0;
         count  <= '0;
      end else if (!i_fold_valid) begin
         loaded <= 1'b0;                  // back to the load state
         count  <= '0;
      end else if (!loaded) begin
         loaded <= 1'b1;                  // edge 2, start vector goes in
         count  <= '0;
      end else if (rot_en) begin
         count  <= count + 1'b1;          // edges 3 .. 18
      end
   end

   // datapath, frozen once count reaches the end
   always_ff @(posedge i_clk) begin
      if (i_fold_valid && !loaded) begin
         x_q <= x_init;
         y_q <= '0;
         z_q <= signed'(i_fold_z);
      end else if (rot_en) begin
         if (z_neg) begin                 // angle overshot, turn clockwise
            x_q <= x_q + y_sh;
            y_q <= y_q - x_sh;
            z_q <= z_q + step_s;
         end else begin                   // still short, turn counter-clockwise
            x_q <= x_q - y_sh;
            y_q <= y_q + x_sh;
            z_q <= z_q - step_s;
         end
      end
   end

   assign o_vec.x = x_q;
   assign o_vec.y = y_q;
   // rises after edge 18, falls one edge after valid drops
   assign o_done  = loaded && (count == iter_end);

endmodule

// File: hw/result_unfold.sv
`timescale 1ns/1ps
`include "cordic_defs.svh"

module result_unfold (
   input    logic                   i_clk,
   input    logic                   i_nrst,
   input    angle_pkg::quadrant_t   i_quad,     // quadrant of the original angle
   input    vector_pkg::vec_t       i_vec,      // first-quadrant cos (x) and sin (y)
   input    logic                   i_done,     // core finished, vector is final
   output   vector_pkg::sincos_t    o_result,   // full-circle sin/cos, Q1.14
   output   logic                   o_ack       // level back to the caller
);

   localparam int frac_g   = `XY_W - `DATA_W;       // bits dropped by rounding
   localparam int rnd_w    = `DATA_W + 2;           // room for round carry and negate
   localparam logic signed [`XY_W:0]   half   = (`XY_W+1)'(2 ** (frac_g - 1));
   localparam logic signed [rnd_w-1:0] sat_hi = rnd_w'((2 ** (`DATA_W - 1)) - 1);
   localparam logic signed [rnd_w-1:0] sat_lo = ~sat_hi;   // most negative sample

   logic signed [rnd_w-1:0]   s, c;          // rounded first-quadrant sin, cos
   logic signed [rnd_w-1:0]   sin_w, cos_w;  // after the quadrant swap

   // round half up, then drop the guard bits
   function automatic logic signed [rnd_w-1:0] round_xy(input logic signed [`XY_W-1:0] v);
      logic signed [`XY_W:0] t;
      t = v;                                 // sign extends by one bit
      t = t + half;
      return rnd_w'(t >>> frac_g);
   endfunction

   // clip to the output range, only 1.0 itself can spill over
   function automatic logic signed [`DATA_W-1:0] sat(input logic signed [rnd_w-1:0] v);
      if (v > sat_hi)
         return sat_hi[`DATA_W-1:0];
      else if (v < sat_lo)
         return sat_lo[`DATA_W-1:0];
      else
         return v[`DATA_W-1:0];
   endfunction

   assign s = round_xy(i_vec.y);
   assign c = round_xy(i_vec.x);

   // rotate the first-quadrant result by quad * 90 deg
   always_comb begin
      unique case (i_quad)
         angle_pkg::Q0: begin sin_w =  s; cos_w =  c; end
         angle_pkg::Q1: begin sin_w =  c; cos_w = -s; end
         angle_pkg::Q2: begin sin_w = -s; cos_w = -c; end
         angle_pkg::Q3: begin sin_w = -c; cos_w =  s; end
         default:       begin sin_w =  s; cos_w =  c; end
      endcase
   end

   // result latched once per request, ack follows done
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_result <= '0;
         o_ack    <= 1'b0;
      end else if (!i_done) begin
         o_ack    <= 1'b0;                   // result word keeps its last value
      end else if (!o_ack) begin
         o_result.sin <= sat(sin_w);         // edge 19
         o_result.cos <= sat(cos_w);
         o_ack        <= 1'b1;
      end
   end

endmodule

// File: hw/sincos_top.sv
`timescale 1ns/1ps
`include "cordic_defs.svh"

module sincos_top (
   input    logic                   i_clk,
   input    logic                   i_nrst,
   input    logic [`ANGLE_W-1:0]    i_theta,    // binary angle, hold while i_req is high
   input    logic                   i_req,      // level request
   output   vector_pkg::sincos_t    o_result,   // sin/cos in Q1.14
   output   logic                   o_ack       // level acknowledge, 19 edges after req
);

   angle_pkg::fold_t       fold;          // quadrant + folded angle, held per request
   logic                   fold_valid;    // fold stage loaded
   logic [3:0]             step_idx;      // core asks the table for this entry
   logic [`Z_W-1:0]        step;          // table answer, same cycle
   vector_pkg::vec_t       vec;           // core output vector
   logic                   done;          // core finished

   // stage 1: capture the angle and fold it into the first quadrant
   angle_fold u_fold (
      .i_clk         (i_clk),
      .i_nrst        (i_nrst),
      .i_theta       (i_theta),
      .i_req         (i_req),
      .o_fold        (fold),
      .o_fold_valid  (fold_valid)
   );

   // stage 2: sixteen micro-rotations
   cordic_iter u_core (
      .i_clk         (i_clk),
      .i_nrst        (i_nrst),
      .i_fold_z      (fold.z),
      .i_fold_valid  (fold_valid),
      .o_step_idx    (step_idx),
      .i_step        (step),
      .o_vec         (vec),
      .o_done        (done)
   );

   // arctangent steps, purely combinational
   atan_rom u_rom (
      .i_idx         (step_idx),
      .o_step        (step)
   );

   // stage 3: back to the full circle, ack to the caller
   result_unfold u_unfold (
      .i_clk         (i_clk),
      .i_nrst        (i_nrst),
      .i_quad        (fold.quad),
      .i_vec         (vec),
      .i_done        (done),
      .o_result      (o_result),
      .o_ack         (o_ack)
   );

endmodule

// File: hw/vector_pkg.sv
`include "cordic_defs.svh"

package vector_pkg;

   // working vector of the rotation core
   // x ends up as the cosine and y as the sine, both with guard bits
   typedef struct packed {
      logic signed [`XY_W-1:0]   x;    // cos part
      logic signed [`XY_W-1:0]   y;    // sin part
   } vec_t;

   // full-circle result seen by the caller, signed Q1.14
   typedef struct packed {
      logic signed [`DATA_W-1:0] sin;  // sine sample
      logic signed [`DATA_W-1:0] cos;  // cosine sample
   } sincos_t;

endpackage

// File: include/cordic_defs.svh
`ifndef CORDIC_DEFS_SVH
`define CORDIC_DEFS_SVH

// input angle, binary turn: 2^16 is one full revolution
`define ANGLE_W      16

// output samples are signed Q1.14, so 1.0 maps to 16384
`define DATA_W       16

// internal residual angle, one turn = 2^18 and one quadrant = 2^16
`define Z_W          18

// x/y datapath width, 4 extra fraction bits below Q1.14
`define XY_W         20

// micro-rotations per request, one per clock
`define CORDIC_ITER  16

// 1/K = 0.607253 in Q1.14, pre-scales the start vector
`define CORDIC_X0    9949

`endif

// File: sim.f
+incdir+include
hw/angle_pkg.sv
hw/vector_pkg.sv
hw/atan_rom.sv
hw/angle_fold.sv
hw/cordic_iter.sv
hw/result_unfold.sv
hw/sincos_top.sv
bench/tb_clkgen.sv
bench/sincos_chk.sv
bench/tb_sincos.sv
